// File: exec_pkg.sv
`default_nettype none

package exec_pkg;

  // datapath width
  parameter int xlen = 64;

  // rob and physical register file sizes
  parameter int num_rob = 32;
  parameter int num_pr = 64;

  typedef logic [$clog2(num_rob)-1:0] rob_idx_t;
  typedef logic [$clog2(num_pr)-1:0] pr_idx_t;

  // target unit of an issue
  typedef enum logic [1:0] {
    unit_alu,
    unit_mult,
    unit_br
  } fu_unit_e;

  // integer operation codes
  typedef enum logic [4:0] {
    alu_addq,
    alu_subq,
    alu_and,
    alu_bic,
    alu_bis,
    alu_ornot,
    alu_xor,
    alu_eqv,
    alu_srl,
    alu_sll,
    alu_sra,
    alu_cmpult,
    alu_cmpeq,
    alu_cmpule,
    alu_cmplt,
    alu_cmple
  } alu_func_e;

  // operand b source
  typedef enum logic [1:0] {
    opb_is_regb,
    opb_is_imm,
    opb_is_br_disp
  } opb_sel_e;

  // branch base source
  typedef enum logic {
    opa_is_npc,
    opa_is_rega
  } opa_sel_e;

  // bit 2 inverts the low condition
  typedef enum logic [2:0] {
    br_lbc,
    br_eq,
    br_lt,
    br_le,
    br_lbs,
    br_ne,
    br_ge,
    br_gt
  } br_cond_e;

  // operate format, literal form
  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] ra;
    logic [7:0] lit;
    logic is_lit;
    logic [6:0] func;
    logic [4:0] rc;
  } inst_op_t;

  // conditional branch format
  typedef struct packed {
    logic [2:0] opcode_hi;
    br_cond_e cond;
    logic [4:0] ra;
    logic [20:0] disp;
  } inst_br_t;

  typedef union packed {
    inst_op_t op;
    inst_br_t br;
  } inst_word_u;

  // entry is squashed if it sits no further from the rollback point than the tail
  function automatic logic rob_squashed(
    input rob_idx_t entry_idx,
    input rob_idx_t rollback_idx,
    input rob_idx_t tail_idx
  );
    rob_idx_t entry_dist;
    rob_idx_t tail_dist;
    entry_dist = entry_idx - rollback_idx;
    tail_dist = tail_idx - rollback_idx;
    return entry_dist <= tail_dist;
  endfunction

endpackage

`default_nettype wire

// File: fu_issue_if.sv
`timescale 1ns/10ps
`default_nettype none

interface fu_issue_if;
  import exec_pkg::*;

  // one issue bundle, shared by all units
  logic ready;
  fu_unit_e unit;
  alu_func_e func;
  inst_word_u inst;
  opa_sel_e opa_sel;
  opb_sel_e opb_sel;
  // operand values from register read
  logic [xlen-1:0] t1_value;
  logic [xlen-1:0] t2_value;
  logic [xlen-1:0] npc;
  // destination and rob tags
  pr_idx_t t_idx;
  rob_idx_t rob_idx;

  // driver side
  modport src (
    output ready, unit, func, inst, opa_sel, opb_sel,
    output t1_value, t2_value, npc, t_idx, rob_idx
  );

  // unit side
  modport fu (
    input ready, unit, func, inst, opa_sel, opb_sel,
    input t1_value, t2_value, npc, t_idx, rob_idx
  );

endinterface

`default_nettype wire

// File: alu_unit.sv
`timescale 1ns/10ps
`default_nettype none

module alu_unit (
  input  logic                       clock,
  input  logic                       reset,
  fu_issue_if.fu                     issue,
  input  logic                       rollback_en,
  input  exec_pkg::rob_idx_t         rollback_idx,
  input  exec_pkg::rob_idx_t         rob_tail,
  input  logic                       stall,
  output logic                       done,
  output logic [exec_pkg::xlen-1:0]  result,
  output exec_pkg::pr_idx_t          t_idx,
  output exec_pkg::rob_idx_t         rob_idx
);
  import exec_pkg::*;

  logic [xlen-1:0] opa;
  logic [xlen-1:0] opb;
  logic [xlen-1:0] alu_out;
  logic [xlen-1:0] sra_fill;
  logic [5:0] shamt;
  logic accept;
  logic issue_kill;
  logic held_kill;

  // signed less-than from sign bits
  function automatic logic signed_lt(input logic [xlen-1:0] a, input logic [xlen-1:0] b);
    if (a[xlen-1] == b[xlen-1]) begin
      // same sign, plain compare works
      return a < b;
    end
    return a[xlen-1];
  endfunction

  assign opa = issue.t1_value;

  // literal is zero extended
  always_comb begin
    case (issue.opb_sel)
      opb_is_imm: opb = {{(xlen-8){1'b0}}, issue.inst.op.lit};
      default:    opb = issue.t2_value;
    endcase
  end

  assign shamt = opb[5:0];
  // ones in the vacated upper bits for negative a
  assign sra_fill = ~({xlen{1'b1}} >> shamt) & {xlen{opa[xlen-1]}};

  always_comb begin
    case (issue.func)
      alu_addq:   alu_out = opa + opb;
      alu_subq:   alu_out = opa - opb;
      alu_and:    alu_out = opa & opb;
      alu_bic:    alu_out = opa & ~opb;
      alu_bis:    alu_out = opa | opb;
      alu_ornot:  alu_out = opa | ~opb;
      alu_xor:    alu_out = opa ^ opb;
      alu_eqv:    alu_out = opa ^ ~opb;
      alu_srl:    alu_out = opa >> shamt;
      alu_sll:    alu_out = opa << shamt;
      alu_sra:    alu_out = (opa >> shamt) | sra_fill;
      alu_cmpult: alu_out = {{(xlen-1){1'b0}}, opa < opb};
      alu_cmpeq:  alu_out = {{(xlen-1){1'b0}}, opa == opb};
      alu_cmpule: alu_out = {{(xlen-1){1'b0}}, opa <= opb};
      alu_cmplt:  alu_out = {{(xlen-1){1'b0}}, signed_lt(opa, opb)};
      alu_cmple:  alu_out = {{(xlen-1){1'b0}}, signed_lt(opa, opb) || (opa == opb)};
      default:    alu_out = '0;
    endcase
  end

  // take the issue only while free
  assign accept = issue.ready && (issue.unit == unit_alu) && !stall;
  assign issue_kill = rollback_en && rob_squashed(issue.rob_idx, rollback_idx, rob_tail);
  assign held_kill = rollback_en && rob_squashed(rob_idx, rollback_idx, rob_tail);

  // done is a one-cycle pulse unless stalled
  always_ff @(posedge clock) begin
    if (reset) begin
      done <= 1'b0;
    end else if (stall) begin
      // hold, but rollback still clears
      done <= done && !held_kill;
    end else begin
      done <= accept && !issue_kill;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      result <= alu_out;
      t_idx <= issue.t_idx;
      rob_idx <= issue.rob_idx;
    end
  end

endmodule

`default_nettype wire

// File: mult_stage.sv
`timescale 1ns/10ps
`default_nettype none

module mult_stage #(
  parameter int mult_stages = 4
) (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       advance,
  input  logic                       valid_in,
  input  logic                       rollback_en,
  input  exec_pkg::rob_idx_t         rollback_idx,
  input  exec_pkg::rob_idx_t         rob_tail,
  input  logic [exec_pkg::xlen-1:0]  product_in,
  input  logic [exec_pkg::xlen-1:0]  mplier_in,
  input  logic [exec_pkg::xlen-1:0]  mcand_in,
  input  exec_pkg::pr_idx_t          t_idx_in,
  input  exec_pkg::rob_idx_t         rob_idx_in,
  output logic                       valid_out,
  output logic [exec_pkg::xlen-1:0]  product_out,
  output logic [exec_pkg::xlen-1:0]  mplier_out,
  output logic [exec_pkg::xlen-1:0]  mcand_out,
  output exec_pkg::pr_idx_t          t_idx_out,
  output exec_pkg::rob_idx_t         rob_idx_out
);
  import exec_pkg::*;

  // multiplier bits consumed per stage
  localparam int slice_bits = xlen / mult_stages;

  logic [slice_bits-1:0] mplier_lo;
  logic [xlen-1:0] partial;
  logic [xlen-1:0] next_product;
  logic kill_in;
  logic kill_out;

  assign mplier_lo = mplier_in[slice_bits-1:0];
  // low bits of slice times multiplicand
  assign partial = mcand_in * xlen'(mplier_lo);
  assign next_product = product_in + partial;

  // squash check on incoming and held entries
  assign kill_in = rollback_en && rob_squashed(rob_idx_in, rollback_idx, rob_tail);
  assign kill_out = rollback_en && rob_squashed(rob_idx_out, rollback_idx, rob_tail);

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_out <= 1'b0;
    end else if (advance) begin
      valid_out <= valid_in && !kill_in;
    end else begin
      // frozen, rollback still applies
      valid_out <= valid_out && !kill_out;
    end
  end

  // payload moves only when the pipe advances
  always_ff @(posedge clock) begin
    if (advance) begin
      product_out <= next_product;
      // next slice comes down to the low bits
      mplier_out <= mplier_in >> slice_bits;
      mcand_out <= mcand_in << slice_bits;
      t_idx_out <= t_idx_in;
      rob_idx_out <= rob_idx_in;
    end
  end

endmodule

`default_nettype wire

// File: mult_unit.sv
`timescale 1ns/10ps
`default_nettype none

module mult_unit #(
  parameter int mult_stages = 4
) (
  input  logic                       clock,
  input  logic                       reset,
  fu_issue_if.fu                     issue,
  input  logic                       rollback_en,
  input  exec_pkg::rob_idx_t         rollback_idx,
  input  exec_pkg::rob_idx_t         rob_tail,
  input  logic                       stall,
  output logic                       free,
  output logic                       done,
  output logic [exec_pkg::xlen-1:0]  result,
  output exec_pkg::pr_idx_t          t_idx,
  output exec_pkg::rob_idx_t         rob_idx
);
  import exec_pkg::*;

  logic [xlen-1:0] opb;
  logic advance;
  // index 0 is the unit input, index i+1 the output of stage i
  logic [mult_stages:0] valid_chain;
  logic [xlen-1:0] product_chain [mult_stages+1];
  logic [xlen-1:0] mplier_chain [mult_stages+1];
  logic [xlen-1:0] mcand_chain [mult_stages+1];
  pr_idx_t t_idx_chain [mult_stages+1];
  rob_idx_t rob_idx_chain [mult_stages+1];

  always_comb begin
    case (issue.opb_sel)
      opb_is_imm: opb = {{(xlen-8){1'b0}}, issue.inst.op.lit};
      default:    opb = issue.t2_value;
    endcase
  end

  // whole pipe freezes on cdb stall
  assign advance = ~stall;
  assign free = ~stall;

  assign valid_chain[0] = issue.ready && (issue.unit == unit_mult);
  assign product_chain[0] = '0;
  assign mplier_chain[0] = issue.t1_value;
  assign mcand_chain[0] = opb;
  assign t_idx_chain[0] = issue.t_idx;
  assign rob_idx_chain[0] = issue.rob_idx;

  for (genvar i = 0; i < mult_stages; i++) begin : g_stage
    mult_stage #(
      .mult_stages(mult_stages)
    ) u_mult_stage (
      .clock(clock),
      .reset(reset),
      .advance(advance),
      .valid_in(valid_chain[i]),
      .rollback_en(rollback_en),
      .rollback_idx(rollback_idx),
      .rob_tail(rob_tail),
      .product_in(product_chain[i]),
      .mplier_in(mplier_chain[i]),
      .mcand_in(mcand_chain[i]),
      .t_idx_in(t_idx_chain[i]),
      .rob_idx_in(rob_idx_chain[i]),
      .valid_out(valid_chain[i+1]),
      .product_out(product_chain[i+1]),
      .mplier_out(mplier_chain[i+1]),
      .mcand_out(mcand_chain[i+1]),
      .t_idx_out(t_idx_chain[i+1]),
      .rob_idx_out(rob_idx_chain[i+1])
    );
  end

  // last stage holds the finished product
  assign done = valid_chain[mult_stages];
  assign result = product_chain[mult_stages];
  assign t_idx = t_idx_chain[mult_stages];
  assign rob_idx = rob_idx_chain[mult_stages];

endmodule

`default_nettype wire

// File: branch_unit.sv
`timescale 1ns/10ps
`default_nettype none

module branch_unit (
  input  logic                       clock,
  input  logic                       reset,
  fu_issue_if.fu                     issue,
  input  logic                       rollback_en,
  input  exec_pkg::rob_idx_t         rollback_idx,
  input  exec_pkg::rob_idx_t         rob_tail,
  input  logic                       stall,
  output logic                       done,
  output logic [exec_pkg::xlen-1:0]  result,
  output logic                       take,
  output exec_pkg::pr_idx_t          t_idx,
  output exec_pkg::rob_idx_t         rob_idx
);
  import exec_pkg::*;

  logic [xlen-1:0] cond_val;
  logic [xlen-1:0] base;
  logic [xlen-1:0] offset;
  logic cond_true;
  logic accept;
  logic issue_kill;
  logic held_kill;

  assign cond_val = issue.t1_value;

  // low two bits pick the test, bit 2 negates
  always_comb begin
    case (issue.inst.br.cond[1:0])
      2'b00:   cond_true = ~cond_val[0];
      2'b01:   cond_true = (cond_val == '0);
      2'b10:   cond_true = cond_val[xlen-1];
      default: cond_true = cond_val[xlen-1] || (cond_val == '0);
    endcase
  end

  // target base and word displacement
  assign base = (issue.opa_sel == opa_is_npc) ? issue.npc : issue.t1_value;
  assign offset = (issue.opb_sel == opb_is_regb) ? issue.t2_value :
                  {{(xlen-23){issue.inst.br.disp[20]}}, issue.inst.br.disp, 2'b00};

  assign accept = issue.ready && (issue.unit == unit_br) && !stall;
  assign issue_kill = rollback_en && rob_squashed(issue.rob_idx, rollback_idx, rob_tail);
  assign held_kill = rollback_en && rob_squashed(rob_idx, rollback_idx, rob_tail);

  always_ff @(posedge clock) begin
    if (reset) begin
      done <= 1'b0;
    end else if (stall) begin
      done <= done && !held_kill;
    end else begin
      done <= accept && !issue_kill;
    end
  end

  // target and direction with their tags
  always_ff @(posedge clock) begin
    if (accept) begin
      result <= base + offset;
      take <= cond_true ^ issue.inst.br.cond[2];
      t_idx <= issue.t_idx;
      rob_idx <= issue.rob_idx;
    end
  end

endmodule

`default_nettype wire

// File: exec_cluster.sv
`timescale 1ns/10ps
`default_nettype none

module exec_cluster #(
  parameter int mult_stages = 4
) (
  input  logic                       clock,
  input  logic                       reset,
  // issue bundle
  input  logic                       issue_ready,
  input  exec_pkg::fu_unit_e         issue_unit,
  input  exec_pkg::alu_func_e        issue_func,
  input  exec_pkg::inst_word_u       issue_inst,
  input  exec_pkg::opa_sel_e         issue_opa_sel,
  input  exec_pkg::opb_sel_e         issue_opb_sel,
  input  logic [exec_pkg::xlen-1:0]  issue_t1_value,
  input  logic [exec_pkg::xlen-1:0]  issue_t2_value,
  input  logic [exec_pkg::xlen-1:0]  issue_npc,
  input  exec_pkg::pr_idx_t          issue_t_idx,
  input  exec_pkg::rob_idx_t         issue_rob_idx,
  // rob rollback
  input  logic                       rollback_en,
  input  exec_pkg::rob_idx_t         rollback_idx,
  input  exec_pkg::rob_idx_t         rob_tail,
  // cdb back pressure per unit
  input  logic                       alu_stall,
  input  logic                       mult_stall,
  input  logic                       br_stall,
  output logic                       alu_free,
  output logic                       alu_done,
  output logic [exec_pkg::xlen-1:0]  alu_result,
  output exec_pkg::pr_idx_t          alu_t_idx,
  output exec_pkg::rob_idx_t         alu_rob_idx,
  output logic                       mult_free,
  output logic                       mult_done,
  output logic [exec_pkg::xlen-1:0]  mult_result,
  output exec_pkg::pr_idx_t          mult_t_idx,
  output exec_pkg::rob_idx_t         mult_rob_idx,
  output logic                       br_free,
  output logic                       br_done,
  output logic [exec_pkg::xlen-1:0]  br_result,
  output logic                       br_take,
  output exec_pkg::pr_idx_t          br_t_idx,
  output exec_pkg::rob_idx_t         br_rob_idx
);

  fu_issue_if issue_bus ();

  // fan the issue ports onto the shared bundle
  assign issue_bus.ready = issue_ready;
  assign issue_bus.unit = issue_unit;
  assign issue_bus.func = issue_func;
  assign issue_bus.inst = issue_inst;
  assign issue_bus.opa_sel = issue_opa_sel;
  assign issue_bus.opb_sel = issue_opb_sel;
  assign issue_bus.t1_value = issue_t1_value;
  assign issue_bus.t2_value = issue_t2_value;
  assign issue_bus.npc = issue_npc;
  assign issue_bus.t_idx = issue_t_idx;
  assign issue_bus.rob_idx = issue_rob_idx;

  // single-cycle units are free whenever not stalled
  assign alu_free = ~alu_stall;
  assign br_free = ~br_stall;

  alu_unit u_alu_unit (
    .clock(clock),
    .reset(reset),
    .issue(issue_bus.fu),
    .rollback_en(rollback_en),
    .rollback_idx(rollback_idx),
    .rob_tail(rob_tail),
    .stall(alu_stall),
    .done(alu_done),
    .result(alu_result),
    .t_idx(alu_t_idx),
    .rob_idx(alu_rob_idx)
  );

  mult_unit #(
    .mult_stages(mult_stages)
  ) u_mult_unit (
    .clock(clock),
    .reset(reset),
    .issue(issue_bus.fu),
    .rollback_en(rollback_en),
    .rollback_idx(rollback_idx),
    .rob_tail(rob_tail),
    .stall(mult_stall),
    .free(mult_free),
    .done(mult_done),
    .result(mult_result),
    .t_idx(mult_t_idx),
    .rob_idx(mult_rob_idx)
  );

  branch_unit u_branch_unit (
    .clock(clock),
    .reset(reset),
    .issue(issue_bus.fu),
    .rollback_en(rollback_en),
    .rollback_idx(rollback_idx),
    .rob_tail(rob_tail),
    .stall(br_stall),
    .done(br_done),
    .result(br_result),
    .take(br_take),
    .t_idx(br_t_idx),
    .rob_idx(br_rob_idx)
  );

endmodule

`default_nettype wire

// File: exec_monitor.sv
`timescale 1ns/10ps
`default_nettype none

module exec_monitor #(
  parameter int mult_stages = 4
) (
  input logic        clock,
  input logic        reset,
  input logic        rollback_en,
  input logic [4:0]  rollback_idx,
  input logic [4:0]  rob_tail,
  input logic        alu_stall,
  input logic        mult_stall,
  input logic        br_stall,
  input logic        alu_done,
  input logic [63:0] alu_result,
  input logic [5:0]  alu_t_idx,
  input logic [4:0]  alu_rob_idx,
  input logic        mult_done,
  input logic [63:0] mult_result,
  input logic [5:0]  mult_t_idx,
  input logic [4:0]  mult_rob_idx,
  input logic        br_done,
  input logic [63:0] br_result,
  input logic        br_take,
  input logic [5:0]  br_t_idx,
  input logic [4:0]  br_rob_idx
);

  // one result as the cdb would see it, unit 0 alu, 1 mult, 2 branch
  typedef struct packed {
    logic [1:0]  unit;
    logic [63:0] result;
    logic        take;
    logic [5:0]  t_idx;
    logic [4:0]  rob_idx;
  } expect_t;

  // expected result with the edge it was issued at
  typedef struct {
    expect_t value;
    int      issue_cycle;
    int      stall_base;
  } entry_t;

  // pending results in issue order, all units together
  entry_t pending[$];
  expect_t held [3];
  logic held_valid [3];
  // rising edges seen, and stalled edges per unit
  int cycle = 0;
  int stall_cycles [3] = '{0, 0, 0};
  int error_count = 0;
  int check_count = 0;

  // distance from the rollback point, modulo rob size
  function automatic logic squash_rule(input logic [4:0] entry, input logic [4:0] rb,
                                       input logic [4:0] tail);
    logic [4:0] entry_dist;
    logic [4:0] tail_dist;
    entry_dist = entry - rb;
    tail_dist = tail - rb;
    return entry_dist <= tail_dist;
  endfunction

  function automatic int pending_count();
    return pending.size();
  endfunction

  task automatic flag(input string msg);
    $display("Fail at %0t: %s", $time, msg);
    error_count++;
  endtask

  task automatic expect_result(input logic [1:0] unit, input logic [63:0] result,
                               input logic take, input logic [5:0] t_idx,
                               input logic [4:0] rob_idx);
    entry_t e;
    e.value = '{unit, result, take, t_idx, rob_idx};
    e.issue_cycle = cycle;
    e.stall_base = stall_cycles[unit];
    pending.push_back(e);
  endtask

  // oldest pending entry of one unit, -1 if none
  function automatic int first_pending(input logic [1:0] unit);
    int idx;
    idx = -1;
    for (int i = pending.size() - 1; i >= 0; i--) begin
      if (pending[i].value.unit == unit) begin
        idx = i;
      end
    end
    return idx;
  endfunction

  task automatic check_unit(input logic [1:0] unit, input string name, input logic done,
                            input logic stall, input expect_t got);
    expect_t exp;
    int idx;
    int took;
    int latency;
    // a held result must not move while stalled
    if (held_valid[unit] && done && got !== held[unit]) begin
      flag($sformatf("%s output changed during stall, rob %0d", name, got.rob_idx));
    end
    idx = first_pending(unit);
    // first showing of a result, stalled edges do not count
    if (done && !held_valid[unit] && idx >= 0) begin
      latency = (unit == 2'd1) ? mult_stages : 1;
      took = cycle - pending[idx].issue_cycle;
      took = took - (stall_cycles[unit] - pending[idx].stall_base);
      if (took != latency) begin
        flag($sformatf("%s rob %0d took %0d cycles, expected %0d",
                       name, got.rob_idx, took, latency));
      end
    end
    held_valid[unit] = done && stall;
    held[unit] = got;
    if (done && !stall) begin
      check_count++;
      if (idx < 0) begin
        flag($sformatf("%s unexpected done, rob %0d", name, got.rob_idx));
      end else begin
        exp = pending[idx].value;
        pending.delete(idx);
        if (got !== exp) begin
          flag($sformatf("%s got %h take %b t %0d rob %0d, expected %h take %b t %0d rob %0d",
                         name, got.result, got.take, got.t_idx, got.rob_idx,
                         exp.result, exp.take, exp.t_idx, exp.rob_idx));
        end
      end
    end
    if (stall) begin
      stall_cycles[unit]++;
    end
  endtask

  // drop every pending entry the rollback squashes
  task automatic prune_pending();
    int i;
    i = 0;
    while (i < pending.size()) begin
      if (squash_rule(pending[i].value.rob_idx, rollback_idx, rob_tail)) begin
        pending.delete(i);
      end else begin
        i++;
      end
    end
  endtask

  // outputs still hold last cycle values here
  always @(posedge clock) begin
    if (reset) begin
      for (int u = 0; u < 3; u++) begin
        held_valid[u] = 1'b0;
      end
    end else begin
      check_unit(2'd0, "alu", alu_done, alu_stall,
                 '{2'd0, alu_result, 1'b0, alu_t_idx, alu_rob_idx});
      check_unit(2'd1, "mult", mult_done, mult_stall,
                 '{2'd1, mult_result, 1'b0, mult_t_idx, mult_rob_idx});
      check_unit(2'd2, "branch", br_done, br_stall,
                 '{2'd2, br_result, br_take, br_t_idx, br_rob_idx});
      // results shown this cycle already left, the rest may be squashed
      if (rollback_en) begin
        prune_pending();
      end
    end
    cycle++;
  end

endmodule

`default_nettype wire

// File: tb_exec_cluster.sv
`timescale 1ns/10ps
`default_nettype none

module tb_exec_cluster;
  import exec_pkg::*;

  // multiplier depth under test
  localparam int mult_depth = 4;

  typedef enum int {dir_none, dir_stall, dir_rollback, dir_drain} dir_e;

  typedef struct {
    fu_unit_e unit;
    alu_func_e func;
    opa_sel_e opa_sel;
    opb_sel_e opb_sel;
    logic [63:0] t1;
    logic [63:0] t2;
    logic [63:0] npc;
    inst_word_u inst;
    pr_idx_t t_idx;
    rob_idx_t rob_idx;
    dir_e dir;
    rob_idx_t rb;
    rob_idx_t tail;
    logic [63:0] exp_result;
    logic exp_take;
  } row_t;

  logic clock;
  logic reset;
  logic issue_ready;
  fu_unit_e issue_unit;
  alu_func_e issue_func;
  inst_word_u issue_inst;
  opa_sel_e issue_opa_sel;
  opb_sel_e issue_opb_sel;
  logic [63:0] issue_t1_value;
  logic [63:0] issue_t2_value;
  logic [63:0] issue_npc;
  pr_idx_t issue_t_idx;
  rob_idx_t issue_rob_idx;
  logic rollback_en;
  rob_idx_t rollback_idx;
  rob_idx_t rob_tail;
  logic alu_stall;
  logic mult_stall;
  logic br_stall;
  logic alu_free;
  logic alu_done;
  logic [63:0] alu_result;
  pr_idx_t alu_t_idx;
  rob_idx_t alu_rob_idx;
  logic mult_free;
  logic mult_done;
  logic [63:0] mult_result;
  pr_idx_t mult_t_idx;
  rob_idx_t mult_rob_idx;
  logic br_free;
  logic br_done;
  logic [63:0] br_result;
  logic br_take;
  pr_idx_t br_t_idx;
  rob_idx_t br_rob_idx;

  row_t rows[$];
  row_t row;
  logic [31:0] lcg_state = 32'h1ff6;
  int next_tag = 0;
  int timeouts = 0;

  exec_cluster #(.mult_stages(mult_depth)) u_exec_cluster (.*);

  exec_monitor #(.mult_stages(mult_depth)) u_monitor (.*);

  always #50 clock = ~clock;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // reference behavior of the sixteen operations
  function automatic logic [63:0] alu_model(input alu_func_e f, input logic [63:0] a,
                                            input logic [63:0] b);
    logic [5:0] sh;
    sh = b[5:0];
    case (f)
      alu_addq:   return a + b;
      alu_subq:   return a - b;
      alu_and:    return a & b;
      alu_bic:    return a & ~b;
      alu_bis:    return a | b;
      alu_ornot:  return a | ~b;
      alu_xor:    return a ^ b;
      alu_eqv:    return ~(a ^ b);
      alu_srl:    return a >> sh;
      alu_sll:    return a << sh;
      alu_sra:    return $signed(a) >>> sh;
      alu_cmpult: return {63'd0, a < b};
      alu_cmpeq:  return {63'd0, a == b};
      alu_cmpule: return {63'd0, a <= b};
      alu_cmplt:  return {63'd0, $signed(a) < $signed(b)};
      default:    return {63'd0, $signed(a) <= $signed(b)};
    endcase
  endfunction

  // condition from the low code bits, bit 2 flips it
  function automatic logic branch_take(input logic [2:0] cond, input logic [63:0] v);
    logic base;
    case (cond[1:0])
      2'd0:    base = !v[0];
      2'd1:    base = (v == 64'd0);
      2'd2:    base = $signed(v) < 64'sd0;
      default: base = $signed(v) <= 64'sd0;
    endcase
    return cond[2] ? !base : base;
  endfunction

  function automatic row_t blank_row();
    row_t r;
    r = '{unit: unit_alu, func: alu_addq, opa_sel: opa_is_npc, opb_sel: opb_is_regb,
          t1: '0, t2: '0, npc: '0, inst: '0, t_idx: pr_idx_t'(next_tag),
          rob_idx: rob_idx_t'(next_tag), dir: dir_none, rb: '0, tail: '0,
          exp_result: '0, exp_take: 1'b0};
    next_tag++;
    return r;
  endfunction

  task automatic alu_row(input alu_func_e f, input logic [63:0] a, input logic [63:0] b,
                         input logic lit);
    row_t r;
    r = blank_row();
    r.func = f;
    r.t1 = a;
    r.t2 = b;
    if (lit) begin
      // literal is the low byte, zero extended
      r.opb_sel = opb_is_imm;
      // register b differs so a wrong select shows
      r.t2 = ~b;
      r.inst.op.lit = b[7:0];
      r.exp_result = alu_model(f, a, {56'd0, b[7:0]});
    end else begin
      r.exp_result = alu_model(f, a, b);
    end
    rows.push_back(r);
  endtask

  task automatic mult_row();
    row_t r;
    r = blank_row();
    r.unit = unit_mult;
    r.t1 = {lcg_next(), lcg_next()};
    r.t2 = {lcg_next(), lcg_next()};
    r.exp_result = r.t1 * r.t2;
    rows.push_back(r);
  endtask

  task automatic branch_row(input logic [2:0] cond, input logic [63:0] v,
                            input logic [63:0] npc, input logic [20:0] disp);
    row_t r;
    r = blank_row();
    r.unit = unit_br;
    r.opb_sel = opb_is_br_disp;
    r.t1 = v;
    r.npc = npc;
    r.inst.br.cond = br_cond_e'(cond);
    r.inst.br.disp = disp;
    r.exp_result = npc + (64'($signed(disp)) << 2);
    r.exp_take = branch_take(cond, v);
    rows.push_back(r);
  endtask

  task automatic mark_stall();
    rows[rows.size()-1].dir = dir_stall;
  endtask

  task automatic mark_drain();
    rows[rows.size()-1].dir = dir_drain;
  endtask

  task automatic mark_rollback(input rob_idx_t rob, input rob_idx_t rb, input rob_idx_t tail);
    rows[rows.size()-1].rob_idx = rob;
    rows[rows.size()-1].dir = dir_rollback;
    rows[rows.size()-1].rb = rb;
    rows[rows.size()-1].tail = tail;
  endtask

  function automatic logic unit_free(input fu_unit_e u);
    return (u == unit_alu) ? alu_free : (u == unit_mult) ? mult_free : br_free;
  endfunction

  function automatic logic unit_done(input fu_unit_e u);
    return (u == unit_alu) ? alu_done : (u == unit_mult) ? mult_done : br_done;
  endfunction

  task automatic set_stall(input fu_unit_e u, input logic level);
    case (u)
      unit_alu:  alu_stall = level;
      unit_mult: mult_stall = level;
      default:   br_stall = level;
    endcase
  endtask

  task automatic wait_free(input fu_unit_e u);
    int n;
    n = 0;
    while (!unit_free(u) && n < 20) begin
      @(negedge clock);
      n++;
    end
    if (!unit_free(u)) begin
      $display("timeout: unit %0d never became free", u);
      timeouts++;
    end
  endtask

  task automatic wait_done(input fu_unit_e u);
    int n;
    n = 0;
    while (!unit_done(u) && n < 20) begin
      @(negedge clock);
      n++;
    end
    if (!unit_done(u)) begin
      $display("timeout: unit %0d never raised done", u);
      timeouts++;
    end
  endtask

  // hold the cdb off a showing result for three cycles
  task automatic stall_unit(input fu_unit_e u);
    wait_done(u);
    set_stall(u, 1'b1);
    repeat (3) begin
      @(negedge clock);
      if (unit_free(u)) begin
        u_monitor.flag($sformatf("unit %0d free while stalled", u));
      end
    end
    set_stall(u, 1'b0);
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (u_monitor.pending_count() != 0 && n < 40) begin
      @(negedge clock);
      n++;
    end
    if (u_monitor.pending_count() != 0) begin
      $display("timeout: %0d results never came out", u_monitor.pending_count());
      timeouts++;
    end
  endtask

  task automatic build_table();
    // every operation, register b then literal b
    for (int f = 0; f < 16; f++) begin
      alu_row(alu_func_e'(f), 64'h8000_0000_0000_00f0, 64'h0000_00ff_0000_0024, 1'b0);
      alu_row(alu_func_e'(f), 64'h0123_4567_89ab_cdef, 64'h3f, 1'b1);
    end
    mark_stall();
    alu_row(alu_srl, 64'hdead_beef_0000_0001, 64'h0, 1'b0);
    alu_row(alu_sll, 64'h1, 64'd63, 1'b0);
    alu_row(alu_sra, 64'hf000_0000_0000_0000, 64'd63, 1'b0);
    alu_row(alu_sra, 64'h8000_0000_0000_0010, 64'd4, 1'b1);
    alu_row(alu_cmpult, 64'hffff_ffff_ffff_ffff, 64'd1, 1'b0);
    alu_row(alu_cmplt, 64'hffff_ffff_ffff_ffff, 64'd1, 1'b0);
    alu_row(alu_cmple, 64'h7fff_ffff_ffff_ffff, 64'h7fff_ffff_ffff_ffff, 1'b0);
    alu_row(alu_cmpule, 64'd5, 64'h5, 1'b1);
    // literal with its top bit set
    alu_row(alu_addq, 64'd1, 64'hff, 1'b1);
    mark_drain();
    // back to back products, one stalled at the output
    repeat (8) mult_row();
    mark_stall();
    mult_row();
    mark_drain();
    // five in flight, then rollback from rob 3 with tail 6
    next_tag = 1;
    repeat (6) mult_row();
    mark_rollback(5'd6, 5'd3, 5'd6);
    // wrap around squash of an alu issue
    alu_row(alu_addq, 64'd1, 64'd2, 1'b0);
    mark_rollback(5'd31, 5'd30, 5'd1);
    // branches under rollback, one inside the window and one outside
    branch_row(3'd1, 64'd0, 64'h1000, 21'h10);
    mark_rollback(5'd13, 5'd12, 5'd14);
    branch_row(3'd5, 64'd3, 64'h1000, 21'h10);
    mark_rollback(5'd10, 5'd12, 5'd14);
    for (int c = 0; c < 8; c++) begin
      branch_row(3'(c), 64'd0, 64'h4000, 21'h000ff);
      branch_row(3'(c), 64'hffff_ffff_ffff_fffb, 64'h4000, 21'h1ffff0);
      branch_row(3'(c), 64'd6, 64'h8_0000_0000, 21'h00004);
      branch_row(3'(c), 64'd7, 64'h20, 21'h100000);
    end
    mark_stall();
    branch_row(3'd6, 64'd9, 64'h100, 21'h3);
  endtask

  initial begin
    clock = 1'b0;
    reset = 1'b1;
    issue_ready = 1'b0;
    issue_unit = unit_alu;
    issue_func = alu_addq;
    issue_inst = '0;
    issue_opa_sel = opa_is_npc;
    issue_opb_sel = opb_is_regb;
    issue_t1_value = '0;
    issue_t2_value = '0;
    issue_npc = '0;
    issue_t_idx = '0;
    issue_rob_idx = '0;
    rollback_en = 1'b0;
    rollback_idx = '0;
    rob_tail = '0;
    alu_stall = 1'b0;
    mult_stall = 1'b0;
    br_stall = 1'b0;
    build_table();
    repeat (10) @(negedge clock);
    reset = 1'b0;
    if (alu_done || mult_done || br_done || !alu_free || !mult_free || !br_free) begin
      u_monitor.flag("bad done or free level after reset");
    end
    foreach (rows[i]) begin
      row = rows[i];
      wait_free(row.unit);
      issue_ready = 1'b1;
      issue_unit = row.unit;
      issue_func = row.func;
      issue_inst = row.inst;
      issue_opa_sel = row.opa_sel;
      issue_opb_sel = row.opb_sel;
      issue_t1_value = row.t1;
      issue_t2_value = row.t2;
      issue_npc = row.npc;
      issue_t_idx = row.t_idx;
      issue_rob_idx = row.rob_idx;
      rollback_en = (row.dir == dir_rollback);
      rollback_idx = row.rb;
      rob_tail = row.tail;
      u_monitor.expect_result(row.unit, row.exp_result, row.exp_take, row.t_idx,
                              row.rob_idx);
      @(negedge clock);
      issue_ready = 1'b0;
      rollback_en = 1'b0;
      if (row.dir == dir_stall) begin
        stall_unit(row.unit);
      end else if (row.dir == dir_drain) begin
        drain();
      end
    end
    drain();
    repeat (3) @(negedge clock);
    $display("errors %0d, timeouts %0d, results checked %0d",
             u_monitor.error_count, timeouts, u_monitor.check_count);
    if (u_monitor.error_count == 0 && timeouts == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: exec_cluster.f
exec_pkg.sv
fu_issue_if.sv
alu_unit.sv
mult_stage.sv
mult_unit.sv
branch_unit.sv
exec_cluster.sv
exec_monitor.sv
tb_exec_cluster.sv

// File: run_sim.sh
#!/bin/sh
# build and run the exec_cluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_exec_cluster \
  -f exec_cluster.f -o sim_exec_cluster > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/sim_exec_cluster > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "simulation exited with an error, see sim.log"
  exit 1
fi

if grep -q "^TEST PASSED$" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi
